// ==== logic/cluster_pkg.sv ====
package cluster_pkg;

	////////////////////////////////////////
	// Chunk geometry
	////////////////////////////////////////

	// Positions per chunk, also the sparsemap width
	localparam int CHUNK_LEN = 16;

	// Position or nonzero slot index
	localparam int IDX_W = $clog2(CHUNK_LEN);

	// Nonzero value width, signed
	localparam int VAL_W = 8;

	////////////////////////////////////////
	// Cluster shape
	////////////////////////////////////////

	localparam int CU_NUM = 4;
	localparam int CU_SEL_W = $clog2(CU_NUM);

	// Accumulator and output width
	localparam int ACC_W = 32;

	// Shared IFM buffer serves one read port per unit
	localparam int IFM_RD_PORTS = CU_NUM;

	// A filter buffer is read by its own unit only
	localparam int FIL_RD_PORTS = 1;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	typedef logic [CHUNK_LEN-1:0] sparsemap_t;

	// Named signed type so that array elements stay signed
	typedef logic signed [VAL_W-1:0] val_t;

	// Compressed chunk, nonzero value 0 sits at the low end
	typedef struct packed {
		sparsemap_t           sparsemap;
		val_t [CHUNK_LEN-1:0] values;
	} chunk_word_t;

	typedef logic [CU_NUM-1:0] cu_mask_t;

	typedef logic signed [ACC_W-1:0] acc_t;

endpackage

// ==== logic/chunk_buffer.sv ====
`timescale 1ns/100ps

module chunk_buffer (
	 input  logic                                                    clk_i
	,input  logic                                                    rst_i

	// Write side, one whole chunk per strobe
	,input  logic                                                    wr_valid_i
	,input  logic                                                    wr_sel_i
	,input  cluster_pkg::chunk_word_t                                wr_chunk_i

	// Read side
	,input  logic                                                    rd_sel_i
	,input  logic [cluster_pkg::IFM_RD_PORTS-1:0][cluster_pkg::IDX_W-1:0] rd_addr_i
	,output cluster_pkg::val_t [cluster_pkg::IFM_RD_PORTS-1:0]       rd_data_o
	,output cluster_pkg::sparsemap_t                                 rd_sparsemap_o
);
	import cluster_pkg::*;

	// Two banks, one being computed while the other fills
	chunk_word_t [1:0] bank_r;
	chunk_word_t       rd_chunk_w;

	////////////////////////////////////////
	// Bank write
	////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			bank_r <= '0;
		end else if (wr_valid_i) begin
			bank_r[wr_sel_i] <= wr_chunk_i;
		end
	end

	////////////////////////////////////////
	// Combinational read
	////////////////////////////////////////

	assign rd_chunk_w = bank_r[rd_sel_i];

	assign rd_sparsemap_o = rd_chunk_w.sparsemap;

	// One byte select per read port
	// Filter instances only look at port 0
	always_comb begin
		for (int p = 0; p < IFM_RD_PORTS; p++) begin
			rd_data_o[p] = rd_chunk_w.values[rd_addr_i[p]];
		end
	end

endmodule

// ==== logic/sparse_mac_unit.sv ====
`timescale 1ns/100ps

module sparse_mac_unit (
	 input  logic                          clk_i
	,input  logic                          rst_i

	,input  logic                          run_valid_i
	,input  logic                          acc_clear_i

	// Sparsemaps of the current read banks
	,input  cluster_pkg::sparsemap_t       ifm_sparsemap_i
	,input  cluster_pkg::sparsemap_t       fil_sparsemap_i

	// Nonzero value fetch
	,output logic [cluster_pkg::IDX_W-1:0] ifm_rd_addr_o
	,input  cluster_pkg::val_t             ifm_rd_data_i
	,output logic [cluster_pkg::IDX_W-1:0] fil_rd_addr_o
	,input  cluster_pkg::val_t             fil_rd_data_i

	,output logic                          unit_end_o
	,output cluster_pkg::acc_t             acc_o
);
	import cluster_pkg::*;

	logic                    busy_r;
	sparsemap_t              pending_r;
	logic [IDX_W-1:0]        pos_w;
	logic                    mac_en_w;
	logic signed [2*VAL_W-1:0] prod_w;
	acc_t                    acc_r;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Priority encoder, lowest set bit wins
	function automatic logic [IDX_W-1:0] lowest_bit(input sparsemap_t map);
		logic [IDX_W-1:0] idx;
		idx = '0;
		for (int b = CHUNK_LEN - 1; b >= 0; b--) begin
			if (map[b]) begin
				idx = IDX_W'(b);
			end
		end
		return idx;
	endfunction

	// Number of nonzeros stored ahead of a position
	function automatic logic [IDX_W-1:0] count_below(
		input sparsemap_t       map,
		input logic [IDX_W-1:0] pos
	);
		logic [IDX_W-1:0] cnt;
		cnt = '0;
		for (int b = 0; b < CHUNK_LEN; b++) begin
			if (map[b] && (b < pos)) begin
				cnt = cnt + 1'b1;
			end
		end
		return cnt;
	endfunction

	////////////////////////////////////////
	// Match walk
	////////////////////////////////////////

	assign pos_w = lowest_bit(pending_r);

	// Both maps are held by the stable read banks for the whole run
	assign ifm_rd_addr_o = count_below(ifm_sparsemap_i, pos_w);
	assign fil_rd_addr_o = count_below(fil_sparsemap_i, pos_w);

	assign mac_en_w   = busy_r && (pending_r != '0);
	assign unit_end_o = busy_r && (pending_r == '0);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_r    <= 1'b0;
			pending_r <= '0;
		end else if (!busy_r) begin
			// Run pulses seen while busy are dropped
			if (run_valid_i) begin
				busy_r    <= 1'b1;
				pending_r <= ifm_sparsemap_i & fil_sparsemap_i;
			end
		end else if (pending_r == '0) begin
			busy_r <= 1'b0;
		end else begin
			pending_r[pos_w] <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Multiply and accumulate
	////////////////////////////////////////

	assign prod_w = ifm_rd_data_i * fil_rd_data_i;

	// Accumulator carries over chunks until cleared
	always_ff @(posedge clk_i) begin
		if (rst_i || acc_clear_i) begin
			acc_r <= '0;
		end else if (mac_en_w) begin
			acc_r <= acc_r + acc_t'(prod_w);
		end
	end

	assign acc_o = acc_r;

endmodule

// ==== logic/cluster_control.sv ====
`timescale 1ns/100ps

module cluster_control (
	 input  logic                             clk_i
	,input  logic                             rst_i

	// Filter write gating
	,input  logic                             fil_wr_valid_i
	,input  cluster_pkg::cu_mask_t            fil_cu_mask_i
	,output cluster_pkg::cu_mask_t            fil_wr_valid_o

	// End collection
	,input  cluster_pkg::cu_mask_t            unit_end_i
	,output logic                             total_chunk_end_o

	// Output unit select
	,input  logic [cluster_pkg::CU_SEL_W-1:0] out_sel_i
	,output logic [cluster_pkg::CU_SEL_W-1:0] out_sel_o
);
	import cluster_pkg::*;

	cu_mask_t            end_flag_r;
	cu_mask_t            end_seen_w;
	logic                total_end_r;
	logic [CU_SEL_W-1:0] out_sel_r;

	////////////////////////////////////////
	// Filter write strobes
	////////////////////////////////////////

	// Lands in the unit buffers at the same edge as the IFM write
	assign fil_wr_valid_o = fil_cu_mask_i & {CU_NUM{fil_wr_valid_i}};

	////////////////////////////////////////
	// End flags
	////////////////////////////////////////

	// Units finish at different times, so each end pulse is held
	assign end_seen_w = end_flag_r | unit_end_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			end_flag_r  <= '0;
			total_end_r <= 1'b0;
		end else if (&end_seen_w) begin
			// Last unit in, fire once and start over
			end_flag_r  <= '0;
			total_end_r <= 1'b1;
		end else begin
			end_flag_r  <= end_seen_w;
			total_end_r <= 1'b0;
		end
	end

	assign total_chunk_end_o = total_end_r;

	////////////////////////////////////////
	// Output select
	////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			out_sel_r <= '0;
		end else begin
			out_sel_r <= out_sel_i;
		end
	end

	assign out_sel_o = out_sel_r;

endmodule

// ==== logic/compute_cluster.sv ====
`timescale 1ns/100ps

module compute_cluster (
	 input  logic                             clk_i
	,input  logic                             rst_i

	// IFM chunk path
	,input  cluster_pkg::chunk_word_t         ifm_chunk_i
	,input  logic                             ifm_wr_valid_i
	,input  logic                             ifm_wr_sel_i
	,input  logic                             ifm_rd_sel_i

	// Filter chunk path
	,input  cluster_pkg::chunk_word_t         fil_chunk_i
	,input  logic                             fil_wr_valid_i
	,input  logic                             fil_wr_sel_i
	,input  logic                             fil_rd_sel_i
	,input  cluster_pkg::cu_mask_t            fil_cu_mask_i

	,input  logic                             run_valid_i
	,input  logic                             acc_clear_i
	,input  logic [cluster_pkg::CU_SEL_W-1:0] out_sel_i

	,output logic                             total_chunk_end_o
	,output cluster_pkg::acc_t                out_buf_dat_o
);
	import cluster_pkg::*;

	// Shared IFM buffer
	sparsemap_t                            ifm_sparsemap_w;
	logic [IFM_RD_PORTS-1:0][IDX_W-1:0]    ifm_rd_addr_w;
	val_t [IFM_RD_PORTS-1:0]               ifm_rd_data_w;

	// Per-unit filter buffers
	cu_mask_t                                       fil_wr_valid_w;
	sparsemap_t [CU_NUM-1:0]                        fil_sparsemap_w;
	logic [CU_NUM-1:0][IDX_W-1:0]                   unit_fil_addr_w;
	logic [CU_NUM-1:0][IFM_RD_PORTS-1:0][IDX_W-1:0] fil_rd_addr_w;
	val_t [CU_NUM-1:0][IFM_RD_PORTS-1:0]            fil_rd_data_w;

	cu_mask_t              unit_end_w;
	acc_t [CU_NUM-1:0]     acc_w;
	logic [CU_SEL_W-1:0]   out_sel_w;

	chunk_buffer u_ifm_buf (
		 .clk_i
		,.rst_i
		,.wr_valid_i    (ifm_wr_valid_i)
		,.wr_sel_i      (ifm_wr_sel_i)
		,.wr_chunk_i    (ifm_chunk_i)
		,.rd_sel_i      (ifm_rd_sel_i)
		,.rd_addr_i     (ifm_rd_addr_w)
		,.rd_data_o     (ifm_rd_data_w)
		,.rd_sparsemap_o(ifm_sparsemap_w)
	);

	for (genvar i = 0; i < CU_NUM; i++) begin : gen_unit
		// Only the first filter read port carries an address
		assign fil_rd_addr_w[i] = {{((IFM_RD_PORTS - FIL_RD_PORTS) * IDX_W){1'b0}},
			unit_fil_addr_w[i]};

		chunk_buffer u_fil_buf (
			 .clk_i
			,.rst_i
			,.wr_valid_i    (fil_wr_valid_w[i])
			,.wr_sel_i      (fil_wr_sel_i)
			,.wr_chunk_i    (fil_chunk_i)
			,.rd_sel_i      (fil_rd_sel_i)
			,.rd_addr_i     (fil_rd_addr_w[i])
			,.rd_data_o     (fil_rd_data_w[i])
			,.rd_sparsemap_o(fil_sparsemap_w[i])
		);

		sparse_mac_unit u_mac (
			 .clk_i
			,.rst_i
			,.run_valid_i
			,.acc_clear_i
			,.ifm_sparsemap_i(ifm_sparsemap_w)
			,.fil_sparsemap_i(fil_sparsemap_w[i])
			,.ifm_rd_addr_o  (ifm_rd_addr_w[i])
			,.ifm_rd_data_i  (ifm_rd_data_w[i])
			,.fil_rd_addr_o  (unit_fil_addr_w[i])
			,.fil_rd_data_i  (fil_rd_data_w[i][0])
			,.unit_end_o     (unit_end_w[i])
			,.acc_o          (acc_w[i])
		);
	end

	cluster_control u_ctrl (
		 .clk_i
		,.rst_i
		,.fil_wr_valid_i
		,.fil_cu_mask_i
		,.fil_wr_valid_o   (fil_wr_valid_w)
		,.unit_end_i       (unit_end_w)
		,.total_chunk_end_o
		,.out_sel_i
		,.out_sel_o        (out_sel_w)
	);

	// Result readout by the registered unit select
	assign out_buf_dat_o = acc_w[out_sel_w];

endmodule

// ==== testbench/compute_cluster_checker.sv ====
`timescale 1ns/100ps

module compute_cluster_checker (
	 input  logic                  clk_i
	,input  logic                  rst_i
	,input  logic                  total_chunk_end_i
	,input  logic                  fil_wr_valid_i
	,input  cluster_pkg::cu_mask_t fil_cu_mask_i
	,input  cluster_pkg::cu_mask_t gated_wr_valid_i
);

	// Failed assertions, summed into the testbench result
	int assert_fails = 0;

	////////////////////////////////////////
	// End pulse
	////////////////////////////////////////

	end_single_cycle: assert property (
		@(posedge clk_i) disable iff (rst_i)
		total_chunk_end_i |=> !total_chunk_end_i
	) else begin
		assert_fails++;
		$error("total_chunk_end_o stayed high for more than one cycle");
	end

	// Synchronous reset clears the end register at the edge
	end_low_after_reset: assert property (
		@(posedge clk_i)
		rst_i |=> !total_chunk_end_i
	) else begin
		assert_fails++;
		$error("total_chunk_end_o high right after reset");
	end

	////////////////////////////////////////
	// Filter write gating
	////////////////////////////////////////

	gated_within_mask: assert property (
		@(posedge clk_i) disable iff (rst_i)
		(gated_wr_valid_i & ~fil_cu_mask_i) == '0
	) else begin
		assert_fails++;
		$error("Filter write strobe reached a unit outside the mask");
	end

	gated_needs_strobe: assert property (
		@(posedge clk_i) disable iff (rst_i)
		(|gated_wr_valid_i) |-> fil_wr_valid_i
	) else begin
		assert_fails++;
		$error("Filter write strobe raised without a cluster write");
	end

endmodule

bind compute_cluster compute_cluster_checker u_checker (
	 .clk_i
	,.rst_i
	,.total_chunk_end_i(total_chunk_end_o)
	,.fil_wr_valid_i
	,.fil_cu_mask_i
	,.gated_wr_valid_i (fil_wr_valid_w)
);

// ==== testbench/compute_cluster_tb.sv ====
`timescale 1ns/100ps

module compute_cluster_tb;
	import cluster_pkg::*;

	// Uncompressed chunk, zero where the map is clear
	typedef val_t [CHUNK_LEN-1:0] dense_t;

	localparam int WAIT_LIMIT = 100;

	logic                clk_i;
	logic                rst_i;
	chunk_word_t         ifm_chunk_i;
	logic                ifm_wr_valid_i;
	logic                ifm_wr_sel_i;
	logic                ifm_rd_sel_i;
	chunk_word_t         fil_chunk_i;
	logic                fil_wr_valid_i;
	logic                fil_wr_sel_i;
	logic                fil_rd_sel_i;
	cu_mask_t            fil_cu_mask_i;
	logic                run_valid_i;
	logic                acc_clear_i;
	logic [CU_SEL_W-1:0] out_sel_i;
	logic                total_chunk_end_o;
	acc_t                out_buf_dat_o;

	// Reference model of both banks and the accumulators
	dense_t      ifm_dense [2];
	dense_t      fil_dense [CU_NUM][2];
	acc_t        exp_acc [CU_NUM];
	logic [31:0] rng_state;
	int          acc_errors;
	int          end_errors;
	int          timeouts;

	compute_cluster uut (.*);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	////////////////////////////////////////
	// Stimulus and model helpers
	////////////////////////////////////////

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Nonzero value at every set map position
	function automatic dense_t random_dense(input sparsemap_t map);
		dense_t d;
		val_t   v;
		for (int p = 0; p < CHUNK_LEN; p++) begin
			v = val_t'(next_random());
			if (v == 0) begin
				v = 8'sd1;
			end
			d[p] = map[p] ? v : val_t'(0);
		end
		return d;
	endfunction

	// Nonzeros packed upward, junk in the unused slots
	function automatic chunk_word_t pack_chunk(input dense_t d);
		chunk_word_t c;
		int          n;
		n = 0;
		for (int p = 0; p < CHUNK_LEN; p++) begin
			c.values[p] = val_t'(next_random());
		end
		for (int p = 0; p < CHUNK_LEN; p++) begin
			c.sparsemap[p] = (d[p] != 0);
			if (d[p] != 0) begin
				c.values[n] = d[p];
				n++;
			end
		end
		return c;
	endfunction

	function automatic int match_count(input dense_t a, input dense_t b);
		int n;
		n = 0;
		for (int p = 0; p < CHUNK_LEN; p++) begin
			if (a[p] != 0 && b[p] != 0) begin
				n++;
			end
		end
		return n;
	endfunction

	function automatic acc_t dot_product(input dense_t a, input dense_t b);
		acc_t sum;
		sum = '0;
		for (int p = 0; p < CHUNK_LEN; p++) begin
			if (a[p] != 0 && b[p] != 0) begin
				sum = sum + acc_t'(a[p]) * acc_t'(b[p]);
			end
		end
		return sum;
	endfunction

	task automatic check_acc(input string name, input acc_t exp, input acc_t act);
		if (act !== exp) begin
			acc_errors++;
			$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_end(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			end_errors++;
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////

	task automatic write_ifm(input logic bank, input dense_t d);
		@(posedge clk_i);
		ifm_chunk_i    <= pack_chunk(d);
		ifm_wr_sel_i   <= bank;
		ifm_wr_valid_i <= 1'b1;
		@(posedge clk_i);
		ifm_wr_valid_i <= 1'b0;
		ifm_dense[bank] = d;
	endtask

	task automatic write_fil(input logic bank, input cu_mask_t mask, input dense_t d);
		@(posedge clk_i);
		fil_chunk_i    <= pack_chunk(d);
		fil_wr_sel_i   <= bank;
		fil_cu_mask_i  <= mask;
		fil_wr_valid_i <= 1'b1;
		@(posedge clk_i);
		fil_wr_valid_i <= 1'b0;
		for (int u = 0; u < CU_NUM; u++) begin
			if (mask[u]) begin
				fil_dense[u][bank] = d;
			end
		end
	endtask

	task automatic clear_acc();
		@(posedge clk_i);
		acc_clear_i <= 1'b1;
		@(posedge clk_i);
		acc_clear_i <= 1'b0;
		for (int u = 0; u < CU_NUM; u++) begin
			exp_acc[u] = '0;
		end
	endtask

	// End pulse expected k_max + 2 cycles after the run pulse
	task automatic run_chunk(input string name);
		int   exp_lat;
		int   k;
		int   cycles;
		logic seen;
		@(posedge clk_i);
		exp_lat = 0;
		for (int u = 0; u < CU_NUM; u++) begin
			k = match_count(ifm_dense[ifm_rd_sel_i], fil_dense[u][fil_rd_sel_i]);
			if (k > exp_lat) begin
				exp_lat = k;
			end
			exp_acc[u] += dot_product(ifm_dense[ifm_rd_sel_i], fil_dense[u][fil_rd_sel_i]);
		end
		exp_lat = exp_lat + 2;
		run_valid_i <= 1'b1;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(posedge clk_i);
			run_valid_i <= 1'b0;
			cycles++;
			@(negedge clk_i);
			seen = total_chunk_end_o;
			check_end($sformatf("%s end pulse, cycle %0d", name, cycles),
				cycles == exp_lat, total_chunk_end_o);
		end
		if (!seen) begin
			timeouts++;
			$display("Timed out after %0d cycles waiting for the end pulse in %s",
				WAIT_LIMIT, name);
		end
	endtask

	// Select is registered, so the result shows one cycle later
	task automatic check_all_units(input string name);
		for (int u = 0; u < CU_NUM; u++) begin
			@(posedge clk_i);
			out_sel_i <= CU_SEL_W'(u);
			@(posedge clk_i);
			@(negedge clk_i);
			check_acc($sformatf("%s unit %0d", name, u), exp_acc[u], out_buf_dat_o);
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		logic [CU_NUM-1:0][7:0] k_sets [3];
		sparsemap_t             m;
		rng_state      = 32'hded3;
		rst_i          = 1'b1;
		ifm_chunk_i    = '0;
		ifm_wr_valid_i = 1'b0;
		ifm_wr_sel_i   = 1'b0;
		ifm_rd_sel_i   = 1'b0;
		fil_chunk_i    = '0;
		fil_wr_valid_i = 1'b0;
		fil_wr_sel_i   = 1'b0;
		fil_rd_sel_i   = 1'b0;
		fil_cu_mask_i  = '0;
		run_valid_i    = 1'b0;
		acc_clear_i    = 1'b0;
		out_sel_i      = '0;
		acc_errors     = 0;
		end_errors     = 0;
		timeouts       = 0;
		ifm_dense[0]   = '0;
		ifm_dense[1]   = '0;
		for (int u = 0; u < CU_NUM; u++) begin
			exp_acc[u]      = '0;
			fil_dense[u][0] = '0;
			fil_dense[u][1] = '0;
		end
		repeat (2) @(posedge clk_i);
		rst_i <= 1'b0;
		@(negedge clk_i);
		check_end("reset end pulse", 1'b0, total_chunk_end_o);
		check_all_units("reset");

		// Random chunks, accumulating across runs
		repeat (4) begin
			write_ifm(1'b0, random_dense(sparsemap_t'(next_random())));
			for (int u = 0; u < CU_NUM; u++) begin
				write_fil(1'b0, cu_mask_t'(1 << u), random_dense(sparsemap_t'(next_random())));
			end
			run_chunk("random");
			check_all_units("random");
		end

		// Disjoint maps
		m = sparsemap_t'(next_random());
		write_ifm(1'b0, random_dense(m));
		for (int u = 0; u < CU_NUM; u++) begin
			write_fil(1'b0, cu_mask_t'(1 << u), random_dense(~m));
		end
		run_chunk("zero_match");
		check_all_units("zero_match");

		// Known match counts against a full IFM map
		k_sets[0] = {8'd5, 8'd1, 8'd7, 8'd3};
		k_sets[1] = {8'd16, 8'd0, 8'd0, 8'd0};
		k_sets[2] = {8'd2, 8'd2, 8'd2, 8'd2};
		write_ifm(1'b0, random_dense('1));
		for (int s = 0; s < 3; s++) begin
			for (int u = 0; u < CU_NUM; u++) begin
				m = sparsemap_t'((32'h1 << k_sets[s][u]) - 1);
				write_fil(1'b0, cu_mask_t'(1 << u), random_dense(m));
			end
			run_chunk("timing");
			check_all_units("timing");
		end

		// Partial mask touches units 0 and 2 only
		clear_acc();
		write_fil(1'b0, 4'b0101, random_dense(sparsemap_t'(next_random())));
		run_chunk("mask");
		check_all_units("mask");

		// Fill bank 1 while bank 0 is computed, then swap
		write_ifm(1'b0, random_dense(sparsemap_t'(next_random())));
		fork
			run_chunk("bank0 run");
			begin
				write_ifm(1'b1, random_dense(sparsemap_t'(next_random())));
				for (int u = 0; u < CU_NUM; u++) begin
					write_fil(1'b1, cu_mask_t'(1 << u),
						random_dense(sparsemap_t'(next_random())));
				end
			end
		join
		check_all_units("bank0");
		@(posedge clk_i);
		ifm_rd_sel_i <= 1'b1;
		fil_rd_sel_i <= 1'b1;
		run_chunk("bank1 run");
		check_all_units("bank1 accumulate");
		clear_acc();
		check_all_units("clear");

		$display("Errors: acc %0d, end pulse %0d, timeout %0d, assertion %0d",
			acc_errors, end_errors, timeouts, uut.u_checker.assert_fails);
		if (acc_errors + end_errors + timeouts + uut.u_checker.assert_fails == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== src.f ====
logic/cluster_pkg.sv
logic/chunk_buffer.sv
logic/sparse_mac_unit.sv
logic/cluster_control.sv
logic/compute_cluster.sv
testbench/compute_cluster_checker.sv
testbench/compute_cluster_tb.sv
